//--- list.f
imgPkg.sv
scanPkg.sv
scanCtrl.sv
bankAddrGen.sv
windowShift.sv
windowFetchTop.sv
windowFetch_chk.sv
windowFetchTb.sv

//--- windowFetchTb.sv
`timescale 1ns/1ps
`default_nettype none

module windowFetchTb
	import imgPkg::*, scanPkg::*;
();

	localparam int NUM_WIN     = IMG_ROWS * IMG_COLS;
	localparam int FRAME_LIMIT = IMG_ROWS * ((IMG_COLS + 1) * STEP_CYCLES + ROW_GAP) + 50;
	localparam int NUM_FRAMES  = 3;

	logic                      clk = 1'b0;
	logic                      rstn;
	logic                      start;
	logic                      busy;
	logic      [NUM_BANKS-1:0] bankCs;
	bankAddr_t [NUM_BANKS-1:0] bankAddr;
	pixel_t    [NUM_BANKS-1:0] bankData = '0;
	pixel_t    [NUM_BANKS-1:0] readWord = '0;
	window_t                   win;
	logic                      winValid;

	pixel_t img [IMG_ROWS][IMG_COLS];
	pixel_t bankMem [NUM_BANKS][BANK_DEPTH];
	int     seed;
	int     winCnt = 0;
	int     csCnt = 0;

	windowFetchTop dut (
		.clk      (clk),
		.rstn     (rstn),
		.start    (start),
		.busy     (busy),
		.bankCs   (bankCs),
		.bankAddr (bankAddr),
		.bankData (bankData),
		.win      (win),
		.winValid (winValid)
	);

	initial forever #2 clk = ~clk;

	task automatic stopRun();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic timedOut(input string what);
		$display("timeout while waiting for %s", what);
		stopRun();
	endtask

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Error %s expected %h actual %h", name, exp, act);
			stopRun();
		end
	endtask

	// zero outside the frame
	function automatic pixel_t modelCell(input int r, input int c);
		if (r < 0 || r >= IMG_ROWS || c < 0 || c >= IMG_COLS) begin
			return '0;
		end
		return img[r][c];
	endfunction

	task automatic fillFrame();
		for (int r = 0; r < IMG_ROWS; r++) begin
			for (int c = 0; c < IMG_COLS; c++) begin
				img[r][c] = $random(seed);
				bankMem[r % NUM_BANKS][(r / NUM_BANKS) * IMG_COLS + c] = img[r][c];
			end
		end
	endtask

	task automatic checkWindow(input int n);
		int    wr;
		int    wc;
		string kind;
		wr = n / IMG_COLS;
		wc = n % IMG_COLS;
		checkValue("window count within frame", 1, n < NUM_WIN);
		kind = (wr == 0 || wr == IMG_ROWS - 1 || wc == 0 || wc == IMG_COLS - 1) ?
			"border" : "interior";
		for (int i = 0; i < WIN_DIM; i++) begin
			for (int j = 0; j < WIN_DIM; j++) begin
				checkValue($sformatf("%s window r%0d c%0d cell %0d", kind, wr, wc,
					i * WIN_DIM + j), modelCell(wr - 1 + i, wc - 1 + j), win[i * WIN_DIM + j]);
			end
		end
	endtask

	task automatic checkBanks(input int n);
		logic [NUM_BANKS-1:0] expCs;
		int                   expAddr [NUM_BANKS];
		int                   r;
		checkValue("bank column count within frame", 1, n < NUM_WIN);
		expCs = '0;
		for (int k = 0; k < WIN_DIM; k++) begin
			r = n / IMG_COLS - 1 + k;
			if (r >= 0 && r < IMG_ROWS) begin
				expCs[r % NUM_BANKS]   = 1'b1;
				expAddr[r % NUM_BANKS] = (r / NUM_BANKS) * IMG_COLS + n % IMG_COLS;
			end
		end
		checkValue($sformatf("bank select r%0d c%0d", n / IMG_COLS, n % IMG_COLS),
			expCs, bankCs);
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (expCs[b]) begin
				checkValue($sformatf("bank %0d address c%0d", b, n % IMG_COLS),
					expAddr[b], bankAddr[b]);
			end
		end
	endtask

	////////////////////////////////////////////////////
	// bank model, one cycle read latency
	////////////////////////////////////////////////////
	always @(negedge clk) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			bankData[b] = readWord[b];
			readWord[b] = bankCs[b] ? bankMem[b][bankAddr[b]] : pixel_t'(32'hA5A5_A5A5); // junk when idle
		end
	end

	always @(negedge clk) begin
		if (dut.uChk.failCount != 0) begin
			$display("a concurrent assertion in the checker failed");
			stopRun();
		end
		if (rstn && winValid) begin
			checkWindow(winCnt);
			winCnt++;
		end
		if (rstn && (bankCs != '0)) begin
			checkBanks(csCnt); // pad column selects nothing
			csCnt++;
		end
	end

	task automatic runFrame();
		int guard;
		fillFrame();
		winCnt = 0;
		csCnt  = 0;
		start  = 1'b1;
		@(negedge clk);
		start = 1'b0;
		guard = 0;
		while (!busy) begin
			@(negedge clk);
			guard++;
			if (guard > 10) timedOut("busy to rise after start");
		end
		guard = 0;
		while (busy) begin
			start = (($random(seed) & 3) == 0); // stray strobes, must be ignored
			@(negedge clk);
			guard++;
			if (guard > FRAME_LIMIT) timedOut("busy to fall");
		end
		start = 1'b0;
		guard = 0;
		while (winCnt < NUM_WIN) begin
			@(negedge clk);
			guard++;
			if (guard > 20) timedOut("the last window");
		end
		repeat (20) @(negedge clk); // catch extra strobes
		checkValue("windows per frame", NUM_WIN, winCnt);
		checkValue("bank columns per frame", NUM_WIN, csCnt);
		checkValue("busy after frame", 0, busy);
	endtask

	initial begin
		seed  = 24;
		rstn  = 1'b0;
		start = 1'b0;
		repeat (4) @(negedge clk);
		checkValue("reset busy", 0, busy);
		checkValue("reset winValid", 0, winValid);
		checkValue("reset bankCs", 0, bankCs);
		rstn = 1'b1;
		@(negedge clk);
		checkValue("idle busy", 0, busy);
		checkValue("idle bankCs", 0, bankCs);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			runFrame();
			@(negedge clk);
		end
		if (dut.uChk.failCount == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("%0d concurrent assertion failures", dut.uChk.failCount);
			stopRun();
		end
	end

endmodule

`default_nettype wire

//--- windowFetch_chk.sv
`timescale 1ns/1ps
`default_nettype none

module windowFetchChk
	import imgPkg::*;
(
	input logic                 clk,
	input logic                 rstn,
	input logic                 busy,
	input logic [NUM_BANKS-1:0] bankCs,
	input logic                 winValid
);

	int failCount = 0; // assertion failures so far

	// a window column touches at most WIN_DIM rows
	assert property (@(posedge clk) disable iff (!rstn) $countones(bankCs) <= WIN_DIM)
		else begin
			$error("more than three banks selected in one cycle");
			failCount++;
		end

	assert property (@(posedge clk) disable iff (!rstn) winValid |=> !winValid)
		else begin
			$error("winValid high in two consecutive cycles");
			failCount++;
		end

	assert property (@(posedge clk) disable iff (!rstn) !busy |-> (bankCs == '0))
		else begin
			$error("bank selected while the fetcher is not busy");
			failCount++;
		end

endmodule

bind windowFetchTop windowFetchChk uChk (
	.clk      (clk),
	.rstn     (rstn),
	.busy     (busy),
	.bankCs   (bankCs),
	.winValid (winValid)
);

`default_nettype wire

//--- windowFetchTop.sv
`timescale 1ns/1ps
`default_nettype none

module windowFetchTop
	import imgPkg::*;
(
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      start,
	output logic                      busy,
	output logic      [NUM_BANKS-1:0] bankCs,
	output bankAddr_t [NUM_BANKS-1:0] bankAddr,
	input  pixel_t    [NUM_BANKS-1:0] bankData,
	output window_t                   win,
	output logic                      winValid
);

	logic    fetch;
	rowIdx_t fetchRow;
	colIdx_t fetchCol;
	column_t colData;
	logic    colValid;

	scanCtrl uScan (
		.clk      (clk),
		.rstn     (rstn),
		.start    (start),
		.busy     (busy),
		.fetch    (fetch),
		.fetchRow (fetchRow),
		.fetchCol (fetchCol)
	);

	bankAddrGen uBank (
		.clk      (clk),
		.rstn     (rstn),
		.fetch    (fetch),
		.fetchRow (fetchRow),
		.fetchCol (fetchCol),
		.bankCs   (bankCs),
		.bankAddr (bankAddr),
		.bankData (bankData),
		.colData  (colData),
		.colValid (colValid)
	);

	windowShift uWin (
		.clk      (clk),
		.rstn     (rstn),
		.colData  (colData),
		.colValid (colValid),
		.win      (win),
		.winValid (winValid)
	);

endmodule

`default_nettype wire

//--- windowShift.sv
`timescale 1ns/1ps
`default_nettype none

module windowShift
	import imgPkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  column_t colData,
	input  logic    colValid,
	output window_t win,
	output logic    winValid
);

	colIdx_t colCnt;
	logic    rowStart;

	assign rowStart = (colCnt == '0); // first column of a row

	// IMG_COLS+1 columns per row, the last one is the right pad
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			colCnt   <= '0;
			winValid <= 1'b0;
		end else begin
			winValid <= colValid && !rowStart;
			if (colValid) begin
				if (colCnt == IMG_COLS) begin
					colCnt <= '0;
				end else begin
					colCnt <= colCnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// 3x3 shift window
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (colValid) begin
			for (int r = 0; r < WIN_DIM; r++) begin
				for (int c = 0; c < WIN_DIM - 1; c++) begin
					if (rowStart) begin
						win[r*WIN_DIM + c] <= '0; // left pad
					end else begin
						win[r*WIN_DIM + c] <= win[r*WIN_DIM + c + 1];
					end
				end
				win[r*WIN_DIM + WIN_DIM - 1] <= colData[r]; // newest column on the right
			end
		end
	end

endmodule

`default_nettype wire

//--- bankAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

module bankAddrGen
	import imgPkg::*;
(
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        fetch,
	input  rowIdx_t                     fetchRow,
	input  colIdx_t                     fetchCol,
	output logic      [NUM_BANKS-1:0]   bankCs,
	output bankAddr_t [NUM_BANKS-1:0]   bankAddr,
	input  pixel_t    [NUM_BANKS-1:0]   bankData,
	output column_t                     colData,
	output logic                        colValid
);

	logic      [WIN_DIM-1:0]   rowOk;
	bankSel_t  [WIN_DIM-1:0]   rowBank;
	bankAddr_t [WIN_DIM-1:0]   rowAddr;
	logic      [NUM_BANKS-1:0] csNext;
	bankAddr_t [NUM_BANKS-1:0] addrNext;

	logic                      fetchQ1, fetchQ2;
	logic      [WIN_DIM-1:0]   useQ1, useQ2;
	bankSel_t  [WIN_DIM-1:0]   bankQ1, bankQ2;

	//////////////////////////////////////////////////
	// bank layout and padding per window row
	//////////////////////////////////////////////////
	always_comb begin
		int r;
		rowOk   = '0;
		rowBank = '0;
		rowAddr = '0;
		for (int k = 0; k < WIN_DIM; k++) begin
			r = int'(fetchRow) - WIN_DIM / 2 + k;
			if (r >= 0 && r < IMG_ROWS && fetchCol < IMG_COLS) begin
				rowOk[k]   = 1'b1;
				rowBank[k] = bankSel_t'(r % NUM_BANKS);
				rowAddr[k] = bankAddr_t'((r / NUM_BANKS) * IMG_COLS + int'(fetchCol));
			end
		end
	end

	always_comb begin
		csNext   = '0;
		addrNext = '0;
		for (int k = 0; k < WIN_DIM; k++) begin
			if (fetch && rowOk[k]) begin // neighbouring rows never share a bank
				csNext[rowBank[k]]   = 1'b1;
				addrNext[rowBank[k]] = rowAddr[k];
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			bankCs   <= '0;
			fetchQ1  <= 1'b0;
			fetchQ2  <= 1'b0;
			colValid <= 1'b0;
		end else begin
			bankCs   <= csNext;
			fetchQ1  <= fetch;   // request on the bank port
			fetchQ2  <= fetchQ1; // word on bankData
			colValid <= fetchQ2;
		end
	end

	//////////////////////////////////////////////////
	// steering of returned words
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (csNext[b]) begin
				bankAddr[b] <= addrNext[b];
			end
		end
		useQ1  <= rowOk;
		bankQ1 <= rowBank;
		useQ2  <= useQ1;
		bankQ2 <= bankQ1;
		for (int k = 0; k < WIN_DIM; k++) begin
			colData[k] <= useQ2[k] ? bankData[bankQ2[k]] : '0; // zero outside the frame
		end
	end

endmodule

`default_nettype wire

//--- scanCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module scanCtrl
	import imgPkg::*, scanPkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  logic    start,
	output logic    busy,
	output logic    fetch,
	output rowIdx_t fetchRow,
	output colIdx_t fetchCol
);

	scanState_t state;
	rowIdx_t    rowCnt;
	colIdx_t    colCnt;
	stepCnt_t   stepTimer;
	gapCnt_t    gapCnt;
	logic       startOk;
	logic       lastCol;
	logic       lastRow;

	assign startOk = start && (state == Idle) && !busy; // ignored while a frame runs
	assign lastCol = (colCnt == IMG_COLS);
	assign lastRow = (rowCnt == IMG_ROWS - 1);

	//////////////////////////////////////////////////
	// scan FSM with row and column counters
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= Idle;
			rowCnt    <= '0;
			colCnt    <= '0;
			stepTimer <= '0;
			gapCnt    <= '0;
			busy      <= 1'b0;
			fetch     <= 1'b0;
			fetchRow  <= '0;
			fetchCol  <= '0;
		end else begin
			fetch <= 1'b0;
			busy  <= (state != Idle) || fetch || startOk; // holds through the last bank read
			case (state)
				Idle: begin
					if (startOk) begin
						state     <= Scan;
						rowCnt    <= '0;
						colCnt    <= '0;
						stepTimer <= '0; // first fetch right away
					end
				end
				Scan: begin
					if (stepTimer == '0) begin
						fetch     <= 1'b1;
						fetchRow  <= rowCnt;
						fetchCol  <= colCnt;
						stepTimer <= stepCnt_t'(STEP_CYCLES - 1);
						if (lastCol) begin
							colCnt <= '0;
							if (lastRow) begin
								state <= Idle;
							end else begin
								state  <= RowGap;
								rowCnt <= rowCnt + 1'b1;
								gapCnt <= gapCnt_t'(ROW_GAP - 1);
							end
						end else begin
							colCnt <= colCnt + 1'b1;
						end
					end else begin
						stepTimer <= stepTimer - 1'b1;
					end
				end
				RowGap: begin
					if (gapCnt == '0) begin
						state     <= Scan;
						stepTimer <= '0;
					end else begin
						gapCnt <= gapCnt - 1'b1;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- scanPkg.sv
`default_nettype none

package scanPkg;

	localparam int STEP_CYCLES = 2; // cycles between column fetches
	localparam int ROW_GAP     = 5; // idle cycles between rows

	typedef logic [$clog2(STEP_CYCLES)-1:0] stepCnt_t;
	typedef logic [$clog2(ROW_GAP)-1:0]     gapCnt_t;

	typedef enum logic [1:0] {
		Idle,
		Scan,
		RowGap
	} scanState_t;

endpackage

`default_nettype wire

//--- imgPkg.sv
`default_nettype none

package imgPkg;

	localparam int IMG_ROWS   = 8;
	localparam int IMG_COLS   = 8;
	localparam int NUM_BANKS  = 4; // rows interleaved across banks
	localparam int WIN_DIM    = 3;
	localparam int CH_BITS    = 8;
	localparam int NUM_CH     = 4;
	localparam int BANK_DEPTH = IMG_ROWS / NUM_BANKS * IMG_COLS;

	typedef logic [NUM_CH-1:0][CH_BITS-1:0] pixel_t; // channel 0 in the low byte

	typedef logic [$clog2(BANK_DEPTH)-1:0] bankAddr_t;
	typedef logic [$clog2(NUM_BANKS)-1:0]  bankSel_t;

	// one extra value below zero and one past the last row
	typedef logic signed [$clog2(IMG_ROWS+1):0] rowIdx_t;
	typedef logic [$clog2(IMG_COLS+1)-1:0]      colIdx_t; // IMG_COLS is the pad column

	typedef pixel_t [WIN_DIM-1:0]         column_t; // index 0 is the top row
	typedef pixel_t [WIN_DIM*WIN_DIM-1:0] window_t; // row-major, 0 at top left

endpackage

`default_nettype wire
